//--- src.f
hw/pipe_trace_pkg.sv
hw/stage_tracker.sv
hw/trace_store.sv
hw/retire_unit.sv
hw/pipe_trace.sv
sim/clock_gen.sv
sim/pipe_trace_checker.sv
sim/pipe_trace_tb.sv

//--- Makefile
# Verilator build and run of the pipeline trace testbench

VERILATOR ?= verilator
TOP       ?= pipe_trace_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Test completed successfully

.PHONY: sim clean

# Build, run, and pass only if the pass message shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/pipe_trace_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the pipeline trace unit: random fetch, stall and
// flush, a model of the five stages and a check of every retire
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pipe_trace_tb;

    import pipe_trace_pkg::*;

    localparam int RUN_CYCLES    = 2000;
    localparam int RESET_TIMEOUT = 20;        // Cycles
    localparam int DRAIN_TIMEOUT = 50;

    // Expected retire record
    typedef struct packed {
        tag_t                    tag;
        pc_t                     pc;
        stamp_t [NUM_STAGES-1:0] stamp;       // Entry cycle, indexed by stage
        stamp_t                  stalls;      // Stall cycles spent in IF or ID
    } rec_t;

    logic   clk, rst;
    logic   fetch_valid, stall, flush;
    pc_t    fetch_pc;
    logic   retire_valid;
    pc_t    retire_pc;
    tag_t   retire_tag;
    stamp_t retire_if_stamp, retire_id_stamp, retire_ex_stamp;
    stamp_t retire_mem_stamp, retire_wb_stamp, retire_latency;
    count_t retire_count;

    integer seed;
    int     retired;                          // Retires seen so far
    int     waited;
    logic   drained;

    // Model state
    rec_t                  slot [NUM_STAGES];
    logic [NUM_STAGES-1:0] slot_vld;
    stamp_t                cycle;             // Own cycle count, 0 after reset
    tag_t                  next_tag;
    rec_t                  expect_q [$];      // Records that reached WB

    clock_gen u_clk (.clk(clk), .rst(rst));

    pipe_trace UUT (
        .clk, .rst, .fetch_valid, .fetch_pc, .stall, .flush,
        .retire_valid, .retire_pc, .retire_tag,
        .retire_if_stamp, .retire_id_stamp, .retire_ex_stamp,
        .retire_mem_stamp, .retire_wb_stamp,
        .retire_latency, .retire_count
    );

    bind pipe_trace pipe_trace_checker u_checker (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush),
        .retire_valid(retire_valid), .retire_latency(retire_latency)
    );

    //////////////////////////////////////////////////////////////////////
    // Stage model, one step per rising edge
    //////////////////////////////////////////////////////////////////////
    task automatic step_model();
        rec_t                  nxt [NUM_STAGES];
        logic [NUM_STAGES-1:0] nvld;
        nxt          = slot;
        nvld         = slot_vld;
        nxt[ST_WB]   = slot[ST_MEM];          // MEM and WB always advance
        nvld[ST_WB]  = slot_vld[ST_MEM];
        nxt[ST_MEM]  = slot[ST_EX];
        nvld[ST_MEM] = slot_vld[ST_EX];
        nvld[ST_EX]  = 1'b0;                  // Bubble unless the front end moves
        if (flush) begin
            nvld[ST_IF] = 1'b0;               // Younger instructions never retire
            nvld[ST_ID] = 1'b0;
        end else if (stall) begin
            nxt[ST_IF].stalls = slot[ST_IF].stalls + 1'b1;
            nxt[ST_ID].stalls = slot[ST_ID].stalls + 1'b1;
        end else begin
            nxt[ST_EX]  = slot[ST_ID];
            nvld[ST_EX] = slot_vld[ST_ID];
            nxt[ST_ID]  = slot[ST_IF];
            nvld[ST_ID] = slot_vld[ST_IF];
            nvld[ST_IF] = fetch_valid;
            nxt[ST_IF]  = '0;
            nxt[ST_IF].tag = next_tag;
            nxt[ST_IF].pc  = fetch_pc;
            nxt[ST_IF].stamp[ST_IF] = cycle;
            nxt[ST_ID].stamp[ST_ID] = cycle;
            nxt[ST_EX].stamp[ST_EX] = cycle;
            if (fetch_valid) begin
                next_tag = next_tag + 1'b1;   // Wraps at 64
            end
        end
        nxt[ST_MEM].stamp[ST_MEM] = cycle;
        nxt[ST_WB].stamp[ST_WB]   = cycle;
        slot     = nxt;
        slot_vld = nvld;
        if (slot_vld[ST_WB]) begin
            expect_q.push_back(slot[ST_WB]);
        end
        cycle = cycle + 1'b1;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            slot_vld = '0;
            cycle    = '0;
            next_tag = '0;
            expect_q.delete();
        end else begin
            step_model();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks and stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s expected %0h actual %0h", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    // Compare one retire against the oldest queued record
    task automatic check_retire();
        rec_t exp;
        if (retire_valid === 1'b1) begin
            assert (expect_q.size() != 0) else begin
                $display("Retire at %0t ns with no instruction expected", $time);
                stop_on_error();
            end
            exp = expect_q.pop_front();
            retired++;
            check_field("retire_tag", 32'(retire_tag), 32'(exp.tag));
            check_field("retire_pc", retire_pc, exp.pc);
            check_field("retire_if_stamp", 32'(retire_if_stamp), 32'(exp.stamp[ST_IF]));
            check_field("retire_id_stamp", 32'(retire_id_stamp), 32'(exp.stamp[ST_ID]));
            check_field("retire_ex_stamp", 32'(retire_ex_stamp), 32'(exp.stamp[ST_EX]));
            check_field("retire_mem_stamp", 32'(retire_mem_stamp), 32'(exp.stamp[ST_MEM]));
            check_field("retire_wb_stamp", 32'(retire_wb_stamp), 32'(exp.stamp[ST_WB]));
            check_field("retire_latency", 32'(retire_latency), 32'(exp.stalls) + 32'd4);
            check_field("retire_count", 32'(retire_count), retired);
        end
    endtask

    function automatic int unsigned roll_percent();
        return {$random(seed)} % 100;
    endfunction

    task automatic drive_random();
        if (!(fetch_valid && (stall || flush))) begin  // Offer not taken stays up
            fetch_valid = roll_percent() < 80;
            fetch_pc    = pc_t'({$random(seed)}) & ~pc_t'(3);  // Word aligned
        end
        stall = roll_percent() < 15;
        flush = roll_percent() < 5;
    endtask

    initial begin
        seed        = 32'h90e5_9623;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        retired     = 0;

        // Outputs stay quiet through reset
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (rst) begin
                check_field("retire_valid", 32'(retire_valid), 32'd0);
                check_field("retire_count", 32'(retire_count), 32'd0);
            end
        end while (rst && waited < RESET_TIMEOUT);
        assert (!rst) else begin
            $display("Reset still high after %0d cycles", RESET_TIMEOUT);
            stop_on_error();
        end

        repeat (RUN_CYCLES) begin
            check_retire();
            drive_random();
            @(negedge clk);
        end

        // Drain with the front end quiet
        drained = 1'b0;
        waited  = 0;
        while (!drained && waited < DRAIN_TIMEOUT) begin
            check_retire();
            fetch_valid = 1'b0;
            stall       = 1'b0;
            flush       = 1'b0;
            if (slot_vld == '0 && expect_q.size() == 0) begin
                drained = 1'b1;
            end else begin
                @(negedge clk);
                waited++;
            end
        end

        if (!drained) begin
            $display("Pipeline did not drain within %0d cycles", DRAIN_TIMEOUT);
            stop_on_error();
        end else begin
            check_field("retire_count", 32'(retire_count), retired);
            $display("Retired %0d instructions", retired);
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

//--- sim/pipe_trace_checker.sv
//////////////////////////////////////////////////////////////////////
// Concurrent assertions on the retire strobe and latency,
// bound into the pipeline trace top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pipe_trace_checker (
    input logic                   clk,
    input logic                   rst,
    input logic                   stall,
    input logic                   flush,
    input logic                   retire_valid,
    input pipe_trace_pkg::stamp_t retire_latency
);

    import pipe_trace_pkg::*;

    // Reset clears the strobe
    assert property (@(posedge clk) rst |=> !retire_valid)
        else $error("retire_valid high after a reset edge");

    // Stall or flush puts a bubble into EX, which shows up as a gap 4 edges later
    assert property (@(posedge clk) disable iff (rst)
        $past(flush || stall, 4) |-> !retire_valid)
        else $error("retire_valid high where a bubble was expected");

    // Fastest path through the five stages
    assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_latency >= stamp_t'(4))
        else $error("retire_latency below 4");

endmodule

//--- sim/clock_gen.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock with a 40 ns period, and reset for the first 8 cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;               // Half of the 40 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);            // 8 reset edges
        @(negedge clk);
        rst <= 1'b0;                          // Released away from the rising edge
    end

endmodule

//--- hw/pipe_trace.sv
//////////////////////////////////////////////////////////////////////
// Pipeline trace unit top: tracker, record store and retire unit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pipe_trace (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_valid,       // Offered fetch
    input  pipe_trace_pkg::pc_t    fetch_pc,
    input  logic                   stall,
    input  logic                   flush,
    output logic                   retire_valid,
    output pipe_trace_pkg::pc_t    retire_pc,
    output pipe_trace_pkg::tag_t   retire_tag,
    output pipe_trace_pkg::stamp_t retire_if_stamp,
    output pipe_trace_pkg::stamp_t retire_id_stamp,
    output pipe_trace_pkg::stamp_t retire_ex_stamp,
    output pipe_trace_pkg::stamp_t retire_mem_stamp,
    output pipe_trace_pkg::stamp_t retire_wb_stamp,
    output pipe_trace_pkg::stamp_t retire_latency,
    output pipe_trace_pkg::count_t retire_count
);

    import pipe_trace_pkg::*;

    // Tracker outputs
    logic [NUM_STAGES-1:0] enter;
    tag_t                  if_tag, id_tag, ex_tag, mem_tag, wb_tag;
    logic                  wb_valid;

    // Store read port
    tag_t   rd_tag;
    pc_t    rd_pc;
    stamp_t rd_if_stamp, rd_id_stamp, rd_ex_stamp, rd_mem_stamp, rd_wb_stamp;

    stage_tracker u_tracker (
        .clk, .rst, .fetch_valid, .stall, .flush,
        .enter, .if_tag, .id_tag, .ex_tag, .mem_tag, .wb_tag,
        .wb_valid
    );

    trace_store u_store (
        .clk, .rst, .enter,
        .if_tag, .id_tag, .ex_tag, .mem_tag, .wb_tag,
        .fetch_pc, .rd_tag,
        .rd_pc, .rd_if_stamp, .rd_id_stamp, .rd_ex_stamp, .rd_mem_stamp, .rd_wb_stamp
    );

    retire_unit u_retire (
        .clk, .rst, .wb_valid, .wb_tag,
        .rd_pc, .rd_if_stamp, .rd_id_stamp, .rd_ex_stamp, .rd_mem_stamp, .rd_wb_stamp,
        .rd_tag, .retire_valid, .retire_tag, .retire_pc,
        .retire_if_stamp, .retire_id_stamp, .retire_ex_stamp,
        .retire_mem_stamp, .retire_wb_stamp,
        .retire_latency, .retire_count
    );

endmodule

//--- hw/retire_unit.sv
//////////////////////////////////////////////////////////////////////
// Retire unit: registers the WB instruction's record, latency
// and a running retire count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module retire_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_valid,          // WB slot occupied
    input  pipe_trace_pkg::tag_t   wb_tag,
    input  pipe_trace_pkg::pc_t    rd_pc,             // Record of rd_tag
    input  pipe_trace_pkg::stamp_t rd_if_stamp,
    input  pipe_trace_pkg::stamp_t rd_id_stamp,
    input  pipe_trace_pkg::stamp_t rd_ex_stamp,
    input  pipe_trace_pkg::stamp_t rd_mem_stamp,
    input  pipe_trace_pkg::stamp_t rd_wb_stamp,
    output pipe_trace_pkg::tag_t   rd_tag,
    output logic                   retire_valid,      // One pulse per instruction
    output pipe_trace_pkg::tag_t   retire_tag,
    output pipe_trace_pkg::pc_t    retire_pc,
    output pipe_trace_pkg::stamp_t retire_if_stamp,
    output pipe_trace_pkg::stamp_t retire_id_stamp,
    output pipe_trace_pkg::stamp_t retire_ex_stamp,
    output pipe_trace_pkg::stamp_t retire_mem_stamp,
    output pipe_trace_pkg::stamp_t retire_wb_stamp,
    output pipe_trace_pkg::stamp_t retire_latency,    // WB minus IF stamp
    output pipe_trace_pkg::count_t retire_count
);

    import pipe_trace_pkg::*;

    assign rd_tag = wb_tag;                           // Look up the WB occupant

    // Strobe and count
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            retire_count <= '0;
        end else begin
            retire_valid <= wb_valid;                 // WB held for one cycle only
            if (wb_valid) begin
                retire_count <= retire_count + count_t'(1);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Record capture
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wb_valid) begin
            retire_tag       <= wb_tag;
            retire_pc        <= rd_pc;
            retire_if_stamp  <= rd_if_stamp;
            retire_id_stamp  <= rd_id_stamp;
            retire_ex_stamp  <= rd_ex_stamp;
            retire_mem_stamp <= rd_mem_stamp;
            retire_wb_stamp  <= rd_wb_stamp;
            // Wraps with the stamps, 4 when nothing stalled
            retire_latency   <= stamp_t'(rd_wb_stamp - rd_if_stamp);
        end
    end

endmodule

//--- hw/trace_store.sv
//////////////////////////////////////////////////////////////////////
// Trace store: free-running cycle counter and the tag-indexed
// record array of PC and stage entry stamps, one read port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module trace_store (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [pipe_trace_pkg::NUM_STAGES-1:0] enter,     // Stage entered on this edge
    input  pipe_trace_pkg::tag_t                  if_tag,    // Slot occupants
    input  pipe_trace_pkg::tag_t                  id_tag,
    input  pipe_trace_pkg::tag_t                  ex_tag,
    input  pipe_trace_pkg::tag_t                  mem_tag,
    input  pipe_trace_pkg::tag_t                  wb_tag,
    input  pipe_trace_pkg::pc_t                   fetch_pc,  // Captured on IF entry
    input  pipe_trace_pkg::tag_t                  rd_tag,
    output pipe_trace_pkg::pc_t                   rd_pc,
    output pipe_trace_pkg::stamp_t                rd_if_stamp,
    output pipe_trace_pkg::stamp_t                rd_id_stamp,
    output pipe_trace_pkg::stamp_t                rd_ex_stamp,
    output pipe_trace_pkg::stamp_t                rd_mem_stamp,
    output pipe_trace_pkg::stamp_t                rd_wb_stamp
);

    import pipe_trace_pkg::*;

    stamp_t cycle_cnt;                              // 0 after reset, wraps

    // Entries from the last edge, written one cycle later once the
    // slot registers show the entered tags
    logic [NUM_STAGES-1:0] pend_q;
    stamp_t                entry_stamp;             // Count before the entry edge
    pc_t                   entry_pc;

    tag_t   slot_tag [NUM_STAGES];
    stamp_t rd_stamp [NUM_STAGES];

    // Record array, one field per stage
    pc_t    pc_mem    [NUM_RECORDS];
    stamp_t stamp_mem [NUM_STAGES][NUM_RECORDS];

    assign slot_tag[ST_IF]  = if_tag;
    assign slot_tag[ST_ID]  = id_tag;
    assign slot_tag[ST_EX]  = ex_tag;
    assign slot_tag[ST_MEM] = mem_tag;
    assign slot_tag[ST_WB]  = wb_tag;

    //////////////////////////////////////////////////////////////////////
    // Cycle counter and entry capture
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
            pend_q    <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + stamp_t'(1);
            pend_q    <= enter;
        end
    end

    always_ff @(posedge clk) begin
        entry_stamp <= cycle_cnt;
        entry_pc    <= fetch_pc;                    // Only used when IF was entered
    end

    //////////////////////////////////////////////////////////////////////
    // Record writes
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (pend_q[ST_IF]) begin
            pc_mem[slot_tag[ST_IF]] <= entry_pc;
        end
        for (int s = 0; s < NUM_STAGES; s++) begin
            if (pend_q[s]) begin
                stamp_mem[s][slot_tag[s]] <= entry_stamp;   // Each field on its own
            end
        end
    end

    // Read port, forwards an entry not yet written
    always_comb begin
        rd_pc = pc_mem[rd_tag];
        if (pend_q[ST_IF] && slot_tag[ST_IF] == rd_tag) begin
            rd_pc = entry_pc;
        end
        for (int s = 0; s < NUM_STAGES; s++) begin
            if (pend_q[s] && slot_tag[s] == rd_tag) begin
                rd_stamp[s] = entry_stamp;          // WB stamp always takes this path
            end else begin
                rd_stamp[s] = stamp_mem[s][rd_tag];
            end
        end
    end

    assign rd_if_stamp  = rd_stamp[ST_IF];
    assign rd_id_stamp  = rd_stamp[ST_ID];
    assign rd_ex_stamp  = rd_stamp[ST_EX];
    assign rd_mem_stamp = rd_stamp[ST_MEM];
    assign rd_wb_stamp  = rd_stamp[ST_WB];

endmodule

//--- hw/stage_tracker.sv
//////////////////////////////////////////////////////////////////////
// Stage tracker: tag allocation and the five stage slots
// Slots advance, hold or take a bubble under stall and flush
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stage_tracker (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   fetch_valid,  // Instruction offered
    input  logic                                   stall,
    input  logic                                   flush,
    output logic [pipe_trace_pkg::NUM_STAGES-1:0]  enter,        // Stage entered on this edge
    output pipe_trace_pkg::tag_t                   if_tag,
    output pipe_trace_pkg::tag_t                   id_tag,
    output pipe_trace_pkg::tag_t                   ex_tag,
    output pipe_trace_pkg::tag_t                   mem_tag,
    output pipe_trace_pkg::tag_t                   wb_tag,
    output logic                                   wb_valid      // WB slot occupied
);

    import pipe_trace_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Slot state
    //////////////////////////////////////////////////////////////////////
    logic [NUM_STAGES-1:0] vld_q;             // Valid bit per slot
    logic [NUM_STAGES-1:0] vld_n;
    tag_t                  tag_q [NUM_STAGES]; // Tag per slot
    tag_t                  tag_n [NUM_STAGES];
    tag_t                  next_tag_q;        // Tag for the next accepted fetch

    logic advance;                            // Front end moves this edge
    logic accept;                             // Fetch taken into IF

    assign advance = !flush && !stall;
    assign accept  = advance && fetch_valid;

    // Next-state slots
    always_comb begin
        vld_n = vld_q;
        tag_n = tag_q;

        // Back end always moves, whatever the front end does
        vld_n[ST_WB]  = vld_q[ST_MEM];
        tag_n[ST_WB]  = tag_q[ST_MEM];
        vld_n[ST_MEM] = vld_q[ST_EX];
        tag_n[ST_MEM] = tag_q[ST_EX];

        if (flush) begin
            vld_n[ST_IF] = 1'b0;              // Younger instructions dropped
            vld_n[ST_ID] = 1'b0;
            vld_n[ST_EX] = 1'b0;              // Bubble into EX
        end else if (stall) begin
            vld_n[ST_EX] = 1'b0;              // IF and ID hold, EX gets a bubble
        end else begin
            vld_n[ST_EX] = vld_q[ST_ID];
            tag_n[ST_EX] = tag_q[ST_ID];
            vld_n[ST_ID] = vld_q[ST_IF];
            tag_n[ST_ID] = tag_q[ST_IF];
            vld_n[ST_IF] = fetch_valid;       // Empty when nothing offered
            tag_n[ST_IF] = next_tag_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Enter strobes
    //////////////////////////////////////////////////////////////////////
    // A held IF or ID slot keeps its valid bit but must not re-enter,
    // so the front two strobes also need the advance condition
    always_comb begin
        enter         = vld_n;
        enter[ST_IF]  = vld_n[ST_IF] && advance;
        enter[ST_ID]  = vld_n[ST_ID] && advance;
    end

    // Slot registers
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
            for (int s = 0; s < NUM_STAGES; s++) begin
                tag_q[s] <= '0;
            end
        end else begin
            vld_q <= vld_n;
            tag_q <= tag_n;
        end
    end

    // Tag allocation, wraps modulo 64
    always_ff @(posedge clk) begin
        if (rst) begin
            next_tag_q <= '0;
        end else if (accept) begin
            next_tag_q <= next_tag_q + tag_t'(1);
        end
    end

    // Current occupants
    assign if_tag   = tag_q[ST_IF];
    assign id_tag   = tag_q[ST_ID];
    assign ex_tag   = tag_q[ST_EX];
    assign mem_tag  = tag_q[ST_MEM];
    assign wb_tag   = tag_q[ST_WB];
    assign wb_valid = vld_q[ST_WB];

endmodule

//--- hw/pipe_trace_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared widths, vector types and stage index names for the
// pipeline trace unit
//////////////////////////////////////////////////////////////////////

package pipe_trace_pkg;

    // Widths
    localparam int TAG_W       = 6;            // 64 records, at most 5 in flight
    localparam int STAMP_W     = 16;           // Cycle stamps wrap
    localparam int PC_W        = 32;
    localparam int COUNT_W     = 16;
    localparam int NUM_STAGES  = 5;
    localparam int NUM_RECORDS = 2 ** TAG_W;   // One record per tag value

    // Vector types
    typedef logic [TAG_W-1:0]   tag_t;         // Instruction tag
    typedef logic [STAMP_W-1:0] stamp_t;       // Cycle number
    typedef logic [PC_W-1:0]    pc_t;          // Instruction address
    typedef logic [COUNT_W-1:0] count_t;       // Retired instruction count

    //////////////////////////////////////////////////////////////////////
    // Stage positions in the enter strobes and stamp fields
    //////////////////////////////////////////////////////////////////////
    localparam int ST_IF  = 0;
    localparam int ST_ID  = 1;
    localparam int ST_EX  = 2;
    localparam int ST_MEM = 3;
    localparam int ST_WB  = 4;

endpackage
